//--- Bender.yml
package:
  name: lspc_vram

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/lspcVramPkg.sv
      - verilog/cpuRegPort.sv
      - verilog/vramWriteQueue.sv
      - verilog/vramSlotWriter.sv
      - verilog/lspcVramTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/lspcVramTb.sv

//--- include/lspcVram_config.svh
//====================================================================
// Widths and depths shared by RTL and testbench
// Queue depth must be a power of two, 2 or more
//====================================================================
`ifndef LSPC_VRAM_CONFIG_SVH
`define LSPC_VRAM_CONFIG_SVH

// VRAM word address, zone bit not included
`define LSPC_VRAM_ADDR_W 15

// CPU bus and VRAM data word
`define LSPC_DATA_W 16

// Pending write commands held between CPU and VRAM
`define LSPC_QUEUE_DEPTH 4

// CLK_24M cycles per memory slot group
// One of these cycles belongs to the CPU
`define LSPC_SLOT_PERIOD 4

`endif

//--- list.f
+incdir+include
verilog/lspcVramPkg.sv
verilog/cpuRegPort.sv
verilog/vramWriteQueue.sv
verilog/vramSlotWriter.sv
verilog/lspcVramTop.sv
verif/lspcVramTb.sv

//--- verif/lspcVramTb.sv
//======================================================================
// Drives the CPU port of lspcVramTop and checks VRAM write pulses
// Stops at the first mismatch; burst data order is checked as a subsequence
//======================================================================
`timescale 1ns/1ns
`default_nettype none

`include "lspcVram_config.svh"

module lspcVramTb;

	// One CPU access with what it should produce
	typedef struct packed
	{
		lspcVramPkg::regSel_e sel;
		logic [`LSPC_DATA_W-1:0] data;
		logic isRead;
		logic [`LSPC_DATA_W-1:0] expRead;
		logic expValid;
		lspcVramPkg::vramWrite_t expWrite;
		logic [3:0] gap;
	} step_t;

	localparam int BURST_LEN = 12;
	localparam logic [`LSPC_VRAM_ADDR_W-1:0] BURST_START = 15'h0200;

	logic CLK_24M;
	logic T73A_OUT;
	lspcVramPkg::regSel_e cpuSel;
	logic [`LSPC_DATA_W-1:0] cpuData;
	logic cpuWriteN;
	logic cpuReadN;
	logic [`LSPC_DATA_W-1:0] cpuReadData;
	logic [`LSPC_VRAM_ADDR_W-1:0] vramAddr;
	logic [`LSPC_DATA_W-1:0] vramData;
	logic lowWrite;
	logic highWrite;

	// Stimulus table and reference model state
	step_t steps[$];
	lspcVramPkg::vramWrite_t expWrites[$];
	lspcVramPkg::vramWrite_t recorded[$];
	logic [`LSPC_DATA_W-1:0] burstData[$];
	lspcVramPkg::vramZone_e modelZone;
	logic [`LSPC_VRAM_ADDR_W-1:0] modelAddr;
	logic [`LSPC_DATA_W-1:0] modelMod;
	lspcVramPkg::vramWrite_t seenWrite;

	lspcVramTop DUT
	(
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.cpuSel(cpuSel),
		.cpuData(cpuData),
		.cpuWriteN(cpuWriteN),
		.cpuReadN(cpuReadN),
		.cpuReadData(cpuReadData),
		.vramAddr(vramAddr),
		.vramData(vramData),
		.lowWrite(lowWrite),
		.highWrite(highWrite)
	);

	initial
	begin
		CLK_24M = 1'b0;
		forever #4 CLK_24M = ~CLK_24M;
	end

	// VRAM write monitor, samples mid cycle
	always @(negedge CLK_24M)
	begin
		if (T73A_OUT && lowWrite && highWrite)
		begin
			$display("Both VRAM zone write strobes high at %0t ns", $time);
			stopRun();
		end
		if (T73A_OUT && (lowWrite || highWrite))
		begin
			seenWrite.zone = lspcVramPkg::vramZone_e'(highWrite);
			seenWrite.addr = vramAddr;
			seenWrite.data = vramData;
			recorded.push_back(seenWrite);
		end
	end

	task automatic stopRun();
		$display("Test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	//======================================================================
	// Compare tasks
	//======================================================================
	task automatic checkWord(input string name, input logic [`LSPC_DATA_W-1:0] exp,
		input logic [`LSPC_DATA_W-1:0] act);
		if (exp !== act)
		begin
			$display("[ERROR] time=%0t %s expected=%h actual=%h", $time, name, exp, act);
			stopRun();
		end
	endtask

	task automatic compareVramWrite(input int idx, input lspcVramPkg::vramWrite_t exp,
		input lspcVramPkg::vramWrite_t act);
		if (exp !== act)
		begin
			$display("[ERROR] time=%0t vramWrite[%0d] expected=%b/%h/%h actual=%b/%h/%h",
				$time, idx, exp.zone, exp.addr, exp.data, act.zone, act.addr, act.data);
			stopRun();
		end
	endtask

	task automatic expectStatus(input lspcVramPkg::portStatus_t exp,
		input lspcVramPkg::portStatus_t act);
		if (exp !== act)
		begin
			$display("[ERROR] time=%0t status expected ovf=%b pend=%b actual ovf=%b pend=%b",
				$time, exp.overflow, exp.pending, act.overflow, act.pending);
			stopRun();
		end
	endtask

	//======================================================================
	// Table building, with the address rule of the port
	//======================================================================
	task automatic writeStep(input lspcVramPkg::regSel_e sel,
		input logic [`LSPC_DATA_W-1:0] data, input logic [3:0] gap, input logic track);
		step_t s;
		s = '0;
		s.sel = sel;
		s.data = data;
		s.gap = gap;
		case (sel)
			lspcVramPkg::regVramAddr:
			begin
				modelZone = lspcVramPkg::vramZone_e'(data[15]);
				modelAddr = data[`LSPC_VRAM_ADDR_W-1:0];
			end
			lspcVramPkg::regVramMod:
				modelMod = data;
			lspcVramPkg::regVramRw:
			begin
				s.expValid = track;
				s.expWrite.zone = modelZone;
				s.expWrite.addr = modelAddr;
				s.expWrite.data = data;
				// Add modulo, wrap in 15 bits, zone untouched
				modelAddr = 15'((32'(modelAddr) + 32'(modelMod)) % 32'h8000);
			end
			default:
				;
		endcase
		steps.push_back(s);
	endtask

	task automatic readStep(input lspcVramPkg::regSel_e sel,
		input logic [`LSPC_DATA_W-1:0] expRead);
		step_t s;
		s = '0;
		s.sel = sel;
		s.isRead = 1'b1;
		s.expRead = expRead;
		steps.push_back(s);
	endtask

	// Strobe low 2 cycles, high 2 cycles
	task automatic cpuAccess(input lspcVramPkg::regSel_e sel,
		input logic [`LSPC_DATA_W-1:0] data, input logic isRead,
		output logic [`LSPC_DATA_W-1:0] readBack);
		@(posedge CLK_24M);
		cpuSel <= sel;
		cpuData <= data;
		if (isRead)
			cpuReadN <= 1'b0;
		else
			cpuWriteN <= 1'b0;
		repeat (2) @(posedge CLK_24M);
		cpuReadN <= 1'b1;
		cpuWriteN <= 1'b1;
		@(negedge CLK_24M);
		readBack = cpuReadData;
		@(posedge CLK_24M);
	endtask

	task automatic runSteps(input int first, input int last);
		step_t s;
		logic [`LSPC_DATA_W-1:0] got;
		for (int i = first; i <= last; i++)
		begin
			s = steps[i];
			cpuAccess(s.sel, s.data, s.isRead, got);
			if (s.isRead && s.sel == lspcVramPkg::regStatus)
				expectStatus(lspcVramPkg::portStatus_t'(s.expRead[1:0]),
					lspcVramPkg::portStatus_t'(got[1:0]));
			if (s.isRead)
				checkWord("cpuReadData", s.expRead, got);
			if (s.expValid)
				expWrites.push_back(s.expWrite);
			repeat (s.gap) @(posedge CLK_24M);
		end
	endtask

	task automatic waitWrites(input int target);
		int waited;
		waited = 0;
		while (recorded.size() < target && waited < 400)
		begin
			@(posedge CLK_24M);
			waited++;
		end
		if (recorded.size() < target)
		begin
			$display("Timed out: %0d of %0d VRAM writes seen", recorded.size(), target);
			stopRun();
		end
	endtask

	//======================================================================
	// Main sequence
	//======================================================================
	initial
	begin
		int seedDummy;
		int burstFirst;
		int base;
		int nRec;
		int j;
		int polls;
		logic [`LSPC_DATA_W-1:0] got;
		lspcVramPkg::portStatus_t expStat;

		T73A_OUT = 1'b0;
		cpuSel = lspcVramPkg::regVramAddr;
		cpuData = '0;
		cpuWriteN = 1'b1;
		cpuReadN = 1'b1;
		seedDummy = $urandom(32'hf415);

		// Reset values
		readStep(lspcVramPkg::regVramAddr, 16'h0000);
		readStep(lspcVramPkg::regVramMod, 16'h0000);
		readStep(lspcVramPkg::regStatus, 16'h0000);
		// Low zone, small modulo, spaced writes
		writeStep(lspcVramPkg::regVramAddr, 16'h0100, 0, 1'b0);
		writeStep(lspcVramPkg::regVramMod, 16'h0023, 0, 1'b0);
		for (int i = 0; i < 6; i++)
			writeStep(lspcVramPkg::regVramRw, 16'($urandom()), 4, 1'b1);
		readStep(lspcVramPkg::regVramAddr, {modelZone, modelAddr});
		readStep(lspcVramPkg::regVramMod, 16'h0023);
		// High zone near the top, wraps on the second write
		writeStep(lspcVramPkg::regVramAddr, 16'hFFF0, 0, 1'b0);
		writeStep(lspcVramPkg::regVramMod, 16'h4D2B, 0, 1'b0);
		for (int i = 0; i < 5; i++)
			writeStep(lspcVramPkg::regVramRw, 16'($urandom()), 4, 1'b1);
		readStep(lspcVramPkg::regVramAddr, {modelZone, modelAddr});
		readStep(lspcVramPkg::regVramMod, 16'h4D2B);
		readStep(lspcVramPkg::regStatus, 16'h0000);
		// Back to back burst, outcome checked afterwards
		burstFirst = steps.size();
		writeStep(lspcVramPkg::regVramAddr, 16'(BURST_START), 0, 1'b0);
		writeStep(lspcVramPkg::regVramMod, 16'h0001, 0, 1'b0);
		for (int i = 0; i < BURST_LEN; i++)
		begin
			burstData.push_back(16'($urandom()));
			writeStep(lspcVramPkg::regVramRw, burstData[i], 0, 1'b0);
		end

		repeat (5) @(posedge CLK_24M);
		T73A_OUT <= 1'b1;
		repeat (20) @(posedge CLK_24M);
		if (recorded.size() != 0)
		begin
			$display("VRAM write seen with no CPU access after reset");
			stopRun();
		end

		runSteps(0, burstFirst - 1);
		waitWrites(expWrites.size());
		repeat (20) @(posedge CLK_24M);
		if (recorded.size() != expWrites.size())
		begin
			$display("More VRAM writes than CPU data port writes");
			stopRun();
		end
		foreach (expWrites[i])
			compareVramWrite(i, expWrites[i], recorded[i]);

		// Overflow burst
		base = recorded.size();
		runSteps(burstFirst, steps.size() - 1);
		polls = 0;
		cpuAccess(lspcVramPkg::regStatus, '0, 1'b1, got);
		while (got[0] && polls < 20)
		begin
			cpuAccess(lspcVramPkg::regStatus, '0, 1'b1, got);
			polls++;
		end
		if (got[0])
		begin
			$display("Timed out waiting for the write queue to drain");
			stopRun();
		end
		nRec = recorded.size() - base;
		if (nRec < 1 || nRec > BURST_LEN)
		begin
			$display("Burst produced %0d VRAM writes", nRec);
			stopRun();
		end
		j = 0;
		for (int i = 0; i < nRec; i++)
		begin
			checkWord("vramAddr", 16'(15'(BURST_START + i)), 16'(recorded[base + i].addr));
			checkWord("highWrite", 16'(0), 16'(recorded[base + i].zone));
			// Dropped writes leave gaps in the issued data only
			while (j < BURST_LEN && burstData[j] !== recorded[base + i].data)
				j++;
			if (j == BURST_LEN)
			begin
				$display("Burst write %0d data out of issue order", i);
				stopRun();
			end
			j++;
		end
		expStat.overflow = (nRec < BURST_LEN);
		expStat.pending = 1'b0;
		expectStatus(expStat, lspcVramPkg::portStatus_t'(got[1:0]));
		cpuAccess(lspcVramPkg::regVramAddr, '0, 1'b1, got);
		checkWord("cpuReadData", 16'(15'(BURST_START + nRec)), got);

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/cpuRegPort.sv
//====================================================================
// CPU register port, no wait states; writes into a full queue are lost
// Data port reads return zero since VRAM reads are not supported
//====================================================================
`timescale 1ns/1ns
`default_nettype none

`include "lspcVram_config.svh"

module cpuRegPort
(
	input wire CLK_24M,
	input wire T73A_OUT,
	input lspcVramPkg::regSel_e cpuSel,
	input wire [`LSPC_DATA_W-1:0] cpuData,
	input wire cpuWriteN,
	input wire cpuReadN,
	input wire full,
	input wire queueNotEmpty,
	output lspcVramPkg::vramWrite_t pushCmd,
	output logic push,
	output logic [`LSPC_DATA_W-1:0] cpuReadData
);

	// Write strobe history for edge detect
	logic writeNPrev;
	logic writeFall;

	// Register file
	lspcVramPkg::vramZone_e zoneReg;
	logic [`LSPC_VRAM_ADDR_W-1:0] addrReg;
	logic [`LSPC_DATA_W-1:0] modReg;
	logic overflow;

	logic [`LSPC_VRAM_ADDR_W-1:0] nextAddr;
	lspcVramPkg::portStatus_t status;
	logic [`LSPC_DATA_W-1:0] readMux;

	// One count per CPU access, on strobe going low
	assign writeFall = writeNPrev & ~cpuWriteN;

	// Modulo add, carry out of bit 14 is lost so the zone stays put
	assign nextAddr = addrReg + modReg[`LSPC_VRAM_ADDR_W-1:0];

	assign status.overflow = overflow;
	assign status.pending = queueNotEmpty;

	//====================================================================
	// Register writes and command issue
	//====================================================================
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			writeNPrev <= 1'b1;
			zoneReg <= lspcVramPkg::zoneLow;
			addrReg <= '0;
			modReg <= '0;
			overflow <= 1'b0;
			push <= 1'b0;
		end
		else
		begin
			writeNPrev <= cpuWriteN;
			push <= 1'b0;
			if (writeFall)
			begin
				case (cpuSel)
					lspcVramPkg::regVramAddr:
					begin
						zoneReg <= lspcVramPkg::vramZone_e'(cpuData[`LSPC_DATA_W-1]);
						addrReg <= cpuData[`LSPC_VRAM_ADDR_W-1:0];
					end
					lspcVramPkg::regVramRw:
					begin
						// No room, drop it and keep the address
						if (full)
							overflow <= 1'b1;
						else
						begin
							push <= 1'b1;
							addrReg <= nextAddr;
						end
					end
					lspcVramPkg::regVramMod:
						modReg <= cpuData;
					default:
						;
				endcase
			end
		end
	end

	// Command payload, sampled with the current address
	always_ff @(posedge CLK_24M)
	begin
		if (writeFall && cpuSel == lspcVramPkg::regVramRw)
		begin
			pushCmd.zone <= zoneReg;
			pushCmd.addr <= addrReg;
			pushCmd.data <= cpuData;
		end
	end

	//====================================================================
	// Read back
	//====================================================================
	always_comb
	begin
		case (cpuSel)
			lspcVramPkg::regVramAddr: readMux = {zoneReg, addrReg};
			lspcVramPkg::regVramMod: readMux = modReg;
			lspcVramPkg::regStatus: readMux = `LSPC_DATA_W'(status);
			default: readMux = '0;
		endcase
	end

	// Holds last value while read enable is high
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
			cpuReadData <= '0;
		else if (!cpuReadN)
			cpuReadData <= readMux;
	end

	// Queue must never see a push while it reports full
	pushNotFull: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		!(push && full))
		else $error("push issued while queue full");

endmodule

`default_nettype wire

//--- verilog/lspcVramPkg.sv
//====================================================================
// Types shared by the VRAM write port and its testbench
//====================================================================
`default_nettype none

`include "lspcVram_config.svh"

package lspcVramPkg;

	// CPU register select, on the low address lines
	typedef enum logic [1:0]
	{
		regVramAddr = 2'd0,
		regVramRw = 2'd1,
		regVramMod = 2'd2,
		regStatus = 2'd3
	} regSel_e;

	// Address bit 15 picks the VRAM zone
	typedef enum logic
	{
		zoneLow = 1'b0,
		zoneHigh = 1'b1
	} vramZone_e;

	// One pending VRAM write
	typedef struct packed
	{
		vramZone_e zone;
		logic [`LSPC_VRAM_ADDR_W-1:0] addr;
		logic [`LSPC_DATA_W-1:0] data;
	} vramWrite_t;

	// Status word, overflow in bit 1 and pending in bit 0
	typedef struct packed
	{
		logic overflow;
		logic pending;
	} portStatus_t;

endpackage

`default_nettype wire

//--- verilog/lspcVramTop.sv
//====================================================================
// CPU to VRAM write path, register port to FIFO to slot writer
//====================================================================
`timescale 1ns/1ns
`default_nettype none

`include "lspcVram_config.svh"

module lspcVramTop
(
	input wire CLK_24M,
	input wire T73A_OUT,
	input lspcVramPkg::regSel_e cpuSel,
	input wire [`LSPC_DATA_W-1:0] cpuData,
	input wire cpuWriteN,
	input wire cpuReadN,
	output logic [`LSPC_DATA_W-1:0] cpuReadData,
	output logic [`LSPC_VRAM_ADDR_W-1:0] vramAddr,
	output logic [`LSPC_DATA_W-1:0] vramData,
	output logic lowWrite,
	output logic highWrite
);

	// Producer to queue
	lspcVramPkg::vramWrite_t pushCmd;
	logic push;
	logic full;

	// Queue to consumer
	lspcVramPkg::vramWrite_t head;
	logic notEmpty;
	logic pop;

	cpuRegPort regPort
	(
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.cpuSel(cpuSel),
		.cpuData(cpuData),
		.cpuWriteN(cpuWriteN),
		.cpuReadN(cpuReadN),
		.full(full),
		.queueNotEmpty(notEmpty),
		.pushCmd(pushCmd),
		.push(push),
		.cpuReadData(cpuReadData)
	);

	vramWriteQueue #(.DEPTH(`LSPC_QUEUE_DEPTH)) writeQueue
	(
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.pushCmd(pushCmd),
		.push(push),
		.pop(pop),
		.head(head),
		.notEmpty(notEmpty),
		.full(full)
	);

	vramSlotWriter slotWriter
	(
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.head(head),
		.notEmpty(notEmpty),
		.pop(pop),
		.vramAddr(vramAddr),
		.vramData(vramData),
		.lowWrite(lowWrite),
		.highWrite(highWrite)
	);

endmodule

`default_nettype wire

//--- verilog/vramSlotWriter.sv
//====================================================================
// Drains the queue in CPU slots only, one write per slot period
// Video fetch slots are left idle
//====================================================================
`timescale 1ns/1ns
`default_nettype none

`include "lspcVram_config.svh"

module vramSlotWriter
(
	input wire CLK_24M,
	input wire T73A_OUT,
	input lspcVramPkg::vramWrite_t head,
	input wire notEmpty,
	output logic pop,
	output logic [`LSPC_VRAM_ADDR_W-1:0] vramAddr,
	output logic [`LSPC_DATA_W-1:0] vramData,
	output logic lowWrite,
	output logic highWrite
);

	localparam int SLOT_W = $clog2(`LSPC_SLOT_PERIOD);

	// Free running slot position
	logic [SLOT_W-1:0] slotCnt;
	logic cpuSlot;

	// Slot 0 of each period is the CPU one
	assign cpuSlot = (slotCnt == '0);

	// Take the head only when something waits
	assign pop = cpuSlot & notEmpty;

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
			slotCnt <= '0;
		else if (slotCnt == SLOT_W'(`LSPC_SLOT_PERIOD - 1))
			slotCnt <= '0;
		else
			slotCnt <= slotCnt + 1'b1;
	end

	//====================================================================
	// VRAM write ports, one cycle after the pop
	//====================================================================
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			lowWrite <= 1'b0;
			highWrite <= 1'b0;
		end
		else
		begin
			// Strobe of the command's zone only
			lowWrite <= pop && (head.zone == lspcVramPkg::zoneLow);
			highWrite <= pop && (head.zone == lspcVramPkg::zoneHigh);
		end
	end

	// Address and data follow the popped entry
	always_ff @(posedge CLK_24M)
	begin
		if (pop)
		begin
			vramAddr <= head.addr;
			vramData <= head.data;
		end
	end

	zoneExclusive: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		!(lowWrite && highWrite))
		else $error("both VRAM zones written at once");

endmodule

`default_nettype wire

//--- verilog/vramWriteQueue.sv
//====================================================================
// Pending write FIFO, DEPTH a power of two and at least 2
// Caller keeps push off when full and pop off when empty
//====================================================================
`timescale 1ns/1ns
`default_nettype none

`include "lspcVram_config.svh"

module vramWriteQueue
#(
	parameter int DEPTH = `LSPC_QUEUE_DEPTH
)
(
	input wire CLK_24M,
	input wire T73A_OUT,
	input lspcVramPkg::vramWrite_t pushCmd,
	input wire push,
	input wire pop,
	output lspcVramPkg::vramWrite_t head,
	output logic notEmpty,
	output logic full
);

	localparam int PTR_W = $clog2(DEPTH);

	lspcVramPkg::vramWrite_t mem [DEPTH];

	// Pointers wrap on their own width
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W:0] count;

	assign head = mem[rdPtr];
	assign notEmpty = (count != '0);
	assign full = (count == (PTR_W+1)'(DEPTH));

	// Storage
	always_ff @(posedge CLK_24M)
	begin
		if (push)
			mem[wrPtr] <= pushCmd;
	end

	// Pointers and occupancy
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			// Both at once leaves the count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	noPushFull: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		push |-> !full)
		else $error("queue overrun");

	noPopEmpty: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		pop |-> notEmpty)
		else $error("queue underrun");

endmodule

`default_nettype wire
